// ==== verilog/attex_pkg.sv ====
package attex_pkg;

    // Request from the 68000-style master, held stable until ack or err
    typedef struct packed {
        logic        as;
        logic        uds;
        logic        lds;
        logic        write_strobe;
        logic [23:0] addr;          // Byte address, bit 0 always zero
        logic [15:0] wdata;
    } cpu_req_t;

    // Page view used for chip selects, flat view for range compares
    typedef struct packed {
        logic [7:0]  page;
        logic [15:0] offset;
    } attex_addr_split_t;

    typedef union packed {
        logic [23:0]       flat;
        attex_addr_split_t split;
    } attex_addr_u;

    typedef enum logic [2:0] {
        region_none,
        region_ext,
        region_nvram,
        region_slave,
        region_err
    } region_e;

    // Reply of one bus slave block
    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } blk_resp_t;

    // Board memory map
    localparam logic [23:0] ext_low_top   = 24'h27FFFF;
    localparam logic [23:0] ext_high_base = 24'h400000;
    localparam logic [23:0] err1_base     = 24'h600000;
    localparam logic [23:0] err1_end      = 24'hD00000;
    localparam logic [23:0] err2_base     = 24'hF00000;

    localparam logic [7:0] page_cdic  = 8'h30;
    localparam logic [7:0] page_slave = 8'h31;
    localparam logic [7:0] page_nvram = 8'h32;

    localparam int nvram_words = 8192;  // 8 kB, one byte per entry

endpackage

// ==== verilog/attex_decoder.sv ====
`timescale 1ns/1ps

module attex_decoder (
    input  attex_pkg::cpu_req_t req,
    output attex_pkg::region_e  region
);

    attex_pkg::attex_addr_u addr_v;

    logic strobe;
    logic err_area;
    logic ext_area;
    logic page_ext;
    logic page_slave;
    logic page_nvram;

    assign addr_v.flat = req.addr;

    assign strobe = req.as && (req.uds || req.lds);

    // RAM mirror holes that the board answers with a bus error
    assign err_area = ((addr_v.flat >= attex_pkg::err1_base) &&
                       (addr_v.flat < attex_pkg::err1_end)) ||
                      (addr_v.flat >= attex_pkg::err2_base);

    // Video chip space, low block plus everything above 0x400000 in the lower half
    assign ext_area = ((addr_v.flat <= attex_pkg::ext_low_top) ||
                       (addr_v.flat >= attex_pkg::ext_high_base)) &&
                      !addr_v.flat[23];

    assign page_ext   = addr_v.split.page == attex_pkg::page_cdic;
    assign page_slave = addr_v.split.page == attex_pkg::page_slave;
    assign page_nvram = addr_v.split.page == attex_pkg::page_nvram;

    always_comb begin
        region = attex_pkg::region_none;
        if (strobe && err_area) begin
            region = attex_pkg::region_err;
        end else if (page_slave) begin
            region = attex_pkg::region_slave;
        end else if (page_nvram) begin
            region = attex_pkg::region_nvram;
        end else if (page_ext || ext_area) begin
            region = attex_pkg::region_ext;  // DMA chip page shares the ext port
        end
    end

endmodule

// ==== verilog/attex_nvram.sv ====
`timescale 1ns/1ps

module attex_nvram (
    input                        clk30,
    input                        reset,
    input  attex_pkg::cpu_req_t  req,
    input                        sel,
    output attex_pkg::blk_resp_t resp
);

    logic [7:0] mem [attex_pkg::nvram_words];

    logic [7:0] readout;
    logic       read_ack;
    logic       sel_q;
    logic       first;

    assign first = sel && !sel_q;

    // Byte wide part sits on the upper lane only
    always_ff @(posedge clk30) begin
        if (sel && req.uds && req.write_strobe) begin
            mem[req.addr[13:1]] <= req.wdata[15:8];
        end
        if (first) begin
            readout <= mem[req.addr[13:1]];
        end
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            sel_q    <= 1'b0;
            read_ack <= 1'b0;
        end else begin
            sel_q    <= sel;
            read_ack <= first && !req.write_strobe;  // One pulse per access
        end
    end

    // Writes complete at once, reads one cycle later
    always_comb begin
        resp.ack   = req.write_strobe ? sel : read_ack;
        resp.rdata = {readout, readout};
    end

endmodule

// ==== verilog/slave_mailbox.sv ====
`timescale 1ns/1ps

module slave_mailbox (
    input                        clk30,
    input                        reset,
    input  attex_pkg::cpu_req_t  req,
    input                        sel,
    output attex_pkg::blk_resp_t resp,
    output logic                 slave_irq,
    output logic [6:0]           slave_addr,
    output logic [15:0]          slave_wdata,
    input                        slave_dtack,
    input  [7:0]                 slave_rdata
);

    logic sel_q;
    logic dtack_q;
    logic start;

    assign start = sel && !sel_q;

    // Control state
    always_ff @(posedge clk30) begin
        if (reset) begin
            sel_q     <= 1'b0;
            dtack_q   <= 1'b0;
            slave_irq <= 1'b0;
        end else begin
            sel_q     <= sel;
            dtack_q   <= slave_dtack;
            slave_irq <= start;   // Single cycle, lines up with the latched access
        end
    end

    // Access seen by the slave controller
    always_ff @(posedge clk30) begin
        if (start) begin
            slave_addr  <= req.addr[7:1];
            slave_wdata <= req.wdata;
        end
    end

    // The slave releases the CPU with a rising edge on dtack
    always_comb begin
        resp.ack   = sel && slave_dtack && !dtack_q;
        resp.rdata = {slave_rdata, slave_rdata};
    end

endmodule

// ==== verilog/bus_response_mux.sv ====
`timescale 1ns/1ps

module bus_response_mux (
    input  attex_pkg::region_e   region,
    input  attex_pkg::blk_resp_t nvram_resp,
    input  attex_pkg::blk_resp_t slave_resp,
    input  attex_pkg::blk_resp_t ext_resp,
    output logic [15:0]          rdata,
    output logic                 bus_ack,
    output logic                 bus_err
);

    always_comb begin
        // Unmapped space terminates at once and reads zero
        rdata   = 16'h0000;
        bus_ack = 1'b1;
        bus_err = 1'b0;

        case (region)
            attex_pkg::region_ext: begin
                rdata   = ext_resp.rdata;
                bus_ack = ext_resp.ack;
            end
            attex_pkg::region_nvram: begin
                rdata   = nvram_resp.rdata;
                bus_ack = nvram_resp.ack;
            end
            attex_pkg::region_slave: begin
                rdata   = slave_resp.rdata;
                bus_ack = slave_resp.ack;
            end
            attex_pkg::region_err: begin
                bus_ack = 1'b0;
                bus_err = 1'b1;
            end
            default: begin
                rdata   = 16'h0000;
                bus_ack = 1'b1;
            end
        endcase
    end

endmodule

// ==== verilog/attex_top.sv ====
`timescale 1ns/1ps

module attex_top (
    input                        clk30,
    input                        reset,
    input  attex_pkg::cpu_req_t  req,
    output logic [15:0]          rdata,
    output logic                 bus_ack,
    output logic                 bus_err,
    output attex_pkg::cpu_req_t  ext_req,
    output logic                 ext_cs,
    input  attex_pkg::blk_resp_t ext_resp,
    output logic                 slave_irq,
    output logic [6:0]           slave_addr,
    output logic [15:0]          slave_wdata,
    input                        slave_dtack,
    input  [7:0]                 slave_rdata
);

    attex_pkg::region_e   region;
    attex_pkg::blk_resp_t nvram_resp;
    attex_pkg::blk_resp_t slave_resp;

    logic nvram_sel;
    logic slave_sel;

    attex_decoder i_attex_decoder (
        .req,
        .region
    );

    // Selects only live while the strobe is up, so each access starts fresh
    assign nvram_sel = (region == attex_pkg::region_nvram) && req.as;
    assign slave_sel = (region == attex_pkg::region_slave) && req.as;
    assign ext_cs    = (region == attex_pkg::region_ext) && req.as;
    assign ext_req   = req;

    attex_nvram i_attex_nvram (
        .clk30,
        .reset,
        .req,
        .sel  (nvram_sel),
        .resp (nvram_resp)
    );

    slave_mailbox i_slave_mailbox (
        .clk30,
        .reset,
        .req,
        .sel  (slave_sel),
        .resp (slave_resp),
        .slave_irq,
        .slave_addr,
        .slave_wdata,
        .slave_dtack,
        .slave_rdata
    );

    bus_response_mux i_bus_response_mux (
        .region,
        .nvram_resp,
        .slave_resp,
        .ext_resp,
        .rdata,
        .bus_ack,
        .bus_err
    );

endmodule

// ==== testbench/attex_props.sv ====
`timescale 1ns/1ps

module attex_props (
    input                       clk30,
    input                       reset,
    input attex_pkg::cpu_req_t  req,
    input attex_pkg::blk_resp_t nvram_resp,
    input attex_pkg::blk_resp_t slave_resp,
    input                       bus_ack,
    input                       bus_err,
    input                       slave_irq
);

    int   fail_count = 0;
    logic err_addr;

    // Error holes of the board map
    assign err_addr = ((req.addr >= attex_pkg::err1_base) &&
                       (req.addr < attex_pkg::err1_end)) ||
                      (req.addr >= attex_pkg::err2_base);

    ack_err_exclusive: assert property (@(posedge clk30) disable iff (reset)
        !(bus_ack && bus_err))
        else begin
            fail_count++;
            $error("bus_ack and bus_err high together");
        end

    irq_single: assert property (@(posedge clk30) disable iff (reset)
        slave_irq |=> !slave_irq)
        else begin
            fail_count++;
            $error("slave_irq held for two cycles");
        end

    // Block replies only while the address strobe is up
    ack_needs_as: assert property (@(posedge clk30) disable iff (reset)
        (nvram_resp.ack || slave_resp.ack) |-> req.as)
        else begin
            fail_count++;
            $error("block ack without address strobe");
        end

    err_on_error_access: assert property (@(posedge clk30) disable iff (reset)
        bus_err |-> (req.as && (req.uds || req.lds) && err_addr))
        else begin
            fail_count++;
            $error("bus_err without a strobed access to an error range");
        end

endmodule

bind attex_top attex_props i_attex_props (
    .clk30,
    .reset,
    .req,
    .nvram_resp,
    .slave_resp,
    .bus_ack,
    .bus_err,
    .slave_irq
);

// ==== testbench/attex_tb.sv ====
`timescale 1ns/1ps

module attex_tb;

    localparam int num_trans      = 400;
    localparam int reset_cycles   = 8;
    localparam int timeout_cycles = num_trans * 12 + reset_cycles + 10;

    logic                 clk30;
    logic                 reset;
    attex_pkg::cpu_req_t  req;
    logic [15:0]          rdata;
    logic                 bus_ack;
    logic                 bus_err;
    attex_pkg::cpu_req_t  ext_req;
    logic                 ext_cs;
    attex_pkg::blk_resp_t ext_resp;
    logic                 slave_irq;
    logic [6:0]           slave_addr;
    logic [15:0]          slave_wdata;
    logic                 slave_dtack;
    logic [7:0]           slave_rdata;

    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          assert_fails;

    // Reference NVRAM with valid bits for the bytes written so far
    logic [7:0] nv_mem [8192];
    bit         nv_valid [8192];

    attex_top i_attex_top (
        .clk30,
        .reset,
        .req,
        .rdata,
        .bus_ack,
        .bus_err,
        .ext_req,
        .ext_cs,
        .ext_resp,
        .slave_irq,
        .slave_addr,
        .slave_wdata,
        .slave_dtack,
        .slave_rdata
    );

    initial clk30 = 1'b0;
    always #50 clk30 = ~clk30;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    // Board map as the master sees it
    function automatic attex_pkg::region_e expect_region(logic [23:0] a, logic strobe);
        if (strobe && (((a >= 24'h600000) && (a < 24'hD00000)) || (a >= 24'hF00000))) begin
            return attex_pkg::region_err;
        end
        case (a[23:16])
            8'h31: return attex_pkg::region_slave;
            8'h32: return attex_pkg::region_nvram;
            8'h30: return attex_pkg::region_ext;
            default: ;
        endcase
        if (!a[23] && ((a < 24'h280000) || (a >= 24'h400000))) begin
            return attex_pkg::region_ext;
        end
        return attex_pkg::region_none;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic attex_pkg::cpu_req_t make_request();
        attex_pkg::cpu_req_t rq;
        logic [31:0]         r;
        logic [31:0]         s;
        logic [7:0]          page;
        r = next_rand();
        s = next_rand();
        rq = '0;
        rq.as = 1'b1;
        rq.write_strobe = s[0];
        rq.uds = s[1];
        rq.lds = s[2];
        rq.wdata = s[31:16];
        page = 8'h33 + 8'(r[27:24] % 13);
        case (s[15:8] % 5)
            0: rq.addr = {8'h32, r[15:14], 8'h00, r[4:0], 1'b0};  // 32 bytes over aliased pages
            1: rq.addr = {8'h31, r[15:1], 1'b0};
            2: begin
                case (r[23:22])
                    2'd0: rq.addr = {8'h30, r[15:1], 1'b0};
                    2'd1: rq.addr = {3'b000, r[20:1], 1'b0};
                    default: rq.addr = {3'b010, r[20:1], 1'b0};
                endcase
            end
            3: begin
                case (r[23:22])
                    2'd0: rq.addr = {3'b011, r[20:1], 1'b0};
                    2'd1: rq.addr = {2'b10, r[21:1], 1'b0};
                    2'd2: rq.addr = {4'hC, r[19:1], 1'b0};
                    default: rq.addr = {4'hF, r[19:1], 1'b0};
                endcase
                rq.uds = s[3];
                rq.lds = !s[3] || s[4];
                if (s[7:6] == 2'b00) begin
                    // No data strobe, so the error ranges fall through
                    rq.uds = 1'b0;
                    rq.lds = 1'b0;
                end
            end
            default: begin
                case (r[23:22])
                    2'd0: rq.addr = {5'b00101, r[18:1], 1'b0};
                    2'd1: rq.addr = {page, r[15:1], 1'b0};
                    default: rq.addr = {(r[20] ? 4'hE : 4'hD), r[19:1], 1'b0};
                endcase
            end
        endcase
        return rq;
    endfunction

    task automatic run_access(input attex_pkg::cpu_req_t rq);
        attex_pkg::region_e exp_region;
        logic [31:0]        r;
        int                 delay;
        int                 cycles;
        int                 irq_count;
        int                 dtack_cycle;
        logic [15:0]        ext_word;
        logic [7:0]         slave_byte;
        logic [12:0]        idx;
        bit                 done;
        exp_region  = expect_region(rq.addr, rq.uds || rq.lds);
        r           = next_rand();
        delay       = r[7:0] % 6;
        ext_word    = r[31:16];
        slave_byte  = r[15:8];
        idx         = rq.addr[13:1];
        cycles      = 0;
        irq_count   = 0;
        dtack_cycle = -1;
        done        = 1'b0;

        @(posedge clk30);
        #1;
        req            = rq;
        ext_resp.ack   = (exp_region == attex_pkg::region_ext) && (delay == 0);
        ext_resp.rdata = ext_word;
        slave_rdata    = slave_byte;

        while (!done) begin
            @(negedge clk30);
            if (slave_irq) begin
                irq_count++;
                dtack_cycle = cycles + 1 + delay;  // Slave answers a few cycles after the irq
                check_value("slave_addr", slave_addr, rq.addr[7:1]);
                check_value("slave_wdata", slave_wdata, rq.wdata);
            end
            if (bus_ack || bus_err) begin
                done = 1'b1;
            end else begin
                @(posedge clk30);
                #1;
                cycles++;
                ext_resp.ack = (exp_region == attex_pkg::region_ext) && (cycles >= delay);
                slave_dtack  = (dtack_cycle >= 0) && (cycles >= dtack_cycle);
            end
        end

        check_value("bus_err", bus_err, exp_region == attex_pkg::region_err);
        check_value("bus_ack", bus_ack, exp_region != attex_pkg::region_err);
        check_value("ext_cs", ext_cs, exp_region == attex_pkg::region_ext);
        case (exp_region)
            attex_pkg::region_ext: begin
                check_value("ext latency", cycles, delay);
                check_value("ext_req", ext_req, rq);
                if (!rq.write_strobe) check_value("ext rdata", rdata, ext_word);
            end
            attex_pkg::region_nvram: begin
                if (rq.write_strobe) begin
                    check_value("nvram write latency", cycles, 0);
                    if (rq.uds) begin
                        nv_mem[idx]   = rq.wdata[15:8];
                        nv_valid[idx] = 1'b1;
                    end
                end else begin
                    check_value("nvram read latency", cycles, 1);
                    if (nv_valid[idx]) begin
                        check_value("nvram rdata", rdata, {nv_mem[idx], nv_mem[idx]});
                    end
                end
            end
            attex_pkg::region_slave: begin
                check_value("slave latency", cycles, dtack_cycle);
                if (!rq.write_strobe) check_value("slave rdata", rdata, {2{slave_byte}});
            end
            attex_pkg::region_none: begin
                check_value("unmapped latency", cycles, 0);
                check_value("unmapped rdata", rdata, 16'h0000);
            end
            default: check_value("bus error latency", cycles, 0);
        endcase
        check_value("slave_irq pulses", irq_count, exp_region == attex_pkg::region_slave);

        // Master releases the bus for one idle cycle
        @(posedge clk30);
        #1;
        req.as       = 1'b0;
        req.uds      = 1'b0;
        req.lds      = 1'b0;
        ext_resp.ack = 1'b0;
        slave_dtack  = 1'b0;
    endtask

    initial begin
        rand_state   = 32'h0045f419;
        errors       = 0;
        checks       = 0;
        assert_fails = 0;
        reset        = 1'b1;
        req          = '0;
        ext_resp     = '0;
        slave_dtack  = 1'b0;
        slave_rdata  = 8'h00;
        repeat (reset_cycles) @(posedge clk30);
        #1;
        reset = 1'b0;
        repeat (num_trans) run_access(make_request());
        @(posedge clk30);
        assert_fails = i_attex_top.i_attex_props.fail_count;
        $display("Accesses %0d, checks %0d, errors %0d, assertion failures %0d",
                 num_trans, checks, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * 100);
        $display("Timeout: a bus access never finished, run stopped at %0t", $time);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/attex_pkg.sv
verilog/attex_decoder.sv
verilog/attex_nvram.sv
verilog/slave_mailbox.sv
verilog/bus_response_mux.sv
verilog/attex_top.sv
testbench/attex_props.sv
testbench/attex_tb.sv

// ==== Bender.yml ====
package:
  name: attex

sources:
  - files:
      - verilog/attex_pkg.sv
      - verilog/attex_decoder.sv
      - verilog/attex_nvram.sv
      - verilog/slave_mailbox.sv
      - verilog/bus_response_mux.sv
      - verilog/attex_top.sv
  - target: simulation
    files:
      - testbench/attex_props.sv
      - testbench/attex_tb.sv
